//--- hw/ilk_pkg.sv
// shared block, word and csr types for the single-lane pcs, imported by every rtl module
package ilk_pkg;

    // one user word as seen on the tx and rx data sides
    typedef struct packed {
        logic [63:0] data;
        logic        ctrl;  // 1 = user control word
    } ilk_word_t;

    // control payload layout, only meaningful when hdr is ilk_hdr_ctrl
    typedef struct packed {
        logic [5:0]  btype;  // block type code
        logic [25:0] rsvd;   // sent as zero
        logic [31:0] value;  // sync pattern, crc or user data
    } ilk_ctrl_t;

    // same 64 bits, decoded by the block header
    typedef union packed {
        logic [63:0] raw;
        ilk_ctrl_t   ctrl;
    } ilk_payload_u;

    // one 66-bit line block
    typedef struct packed {
        logic [1:0]   hdr;
        ilk_payload_u payload;
    } ilk_block_t;

    localparam logic [1:0] ilk_hdr_data = 2'b01;
    localparam logic [1:0] ilk_hdr_ctrl = 2'b10;

    // control block types
    localparam logic [5:0] ilk_type_sync = 6'h1e;
    localparam logic [5:0] ilk_type_diag = 6'h19;
    localparam logic [5:0] ilk_type_idle = 6'h07;
    localparam logic [5:0] ilk_type_user = 6'h2d;  // user control, data in value field

    localparam logic [31:0] ilk_sync_value = 32'h78f6_78f6;  // fixed sync pattern

    // management register offsets, word addressed
    typedef enum logic [7:0] {
        ilk_csr_control = 8'd0,  // bit 0 tx_enable
        ilk_csr_status  = 8'd1,  // read only
        ilk_csr_crc_err = 8'd2,  // write clears
        ilk_csr_ovf     = 8'd3,  // write clears
        ilk_csr_metalen = 8'd4   // read only
    } ilk_csr_addr_e;

    // live lane state reported in the status register
    typedef struct packed {
        logic tx_ready;    // framer is sending blocks
        logic frame_lock;
        logic align_seen;  // sticky, first sync found
    } ilk_status_t;

endpackage

//--- hw/ilk_fifo.sv
// synchronous word fifo with valid/ready on both sides, one instance each for tx and rx
module ilk_fifo #(
    parameter int DEPTH = 16
) (
    input  logic               coreclk,
    input  logic               arst_n,
    input  ilk_pkg::ilk_word_t wr_word,
    input  logic               wr_valid,
    output logic               wr_ready,
    output ilk_pkg::ilk_word_t rd_word,
    output logic               rd_valid,
    input  logic               rd_ready
);
    import ilk_pkg::*;

    localparam int aw = $clog2(DEPTH);

    ilk_word_t   mem [DEPTH];
    logic [aw:0] wr_ptr;  // msb is the wrap bit
    logic [aw:0] rd_ptr;
    logic        full;
    logic        empty;
    logic        wr_fire;
    logic        rd_fire;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[aw] != rd_ptr[aw]) && (wr_ptr[aw-1:0] == rd_ptr[aw-1:0]);

    assign wr_ready = ~full;
    assign rd_valid = ~empty;
    assign wr_fire  = wr_valid & wr_ready;
    assign rd_fire  = rd_valid & rd_ready;

    assign rd_word = mem[rd_ptr[aw-1:0]];  // head word, no read latency

    // storage, written one cycle before it can be read
    always_ff @(posedge coreclk) begin
        if (wr_fire) begin
            mem[wr_ptr[aw-1:0]] <= wr_word;
        end
    end

    always_ff @(posedge coreclk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_fire) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_fire) begin
                rd_ptr <= rd_ptr + 1'b1;  // may pop while pushing
            end
        end
    end

endmodule

//--- hw/ilk_crc32.sv
// crc32 accumulator over one 64-bit word per enabled cycle, owned by framer and deframer
module ilk_crc32 (
    input  logic        coreclk,
    input  logic        arst_n,
    input  logic        clear,   // reload seed, wins over enable
    input  logic        enable,
    input  logic [63:0] data,
    output logic [31:0] crc
);

    localparam logic [31:0] poly = 32'h04c1_1db7;
    localparam logic [31:0] seed = 32'hffff_ffff;

    // 64 serial steps, msb of the word first
    function automatic logic [31:0] crc_step(input logic [31:0] c, input logic [63:0] d);
        logic [31:0] r;
        logic        fb;
        r = c;
        for (int i = 63; i >= 0; i--) begin
            fb = r[31] ^ d[i];
            r  = {r[30:0], 1'b0} ^ (fb ? poly : 32'h0);
        end
        return r;
    endfunction

    always_ff @(posedge coreclk or negedge arst_n) begin
        if (!arst_n) begin
            crc <= seed;
        end else if (clear) begin
            crc <= seed;
        end else if (enable) begin
            crc <= crc_step(crc, data);
        end
    end

endmodule

//--- hw/ilk_tx_framer.sv
// tx framer: wraps fifo words into metaframes with sync, idle and crc diagnostic blocks
module ilk_tx_framer #(
    parameter int METALEN = 64
) (
    input  logic                coreclk,
    input  logic                arst_n,
    input  logic                enable,
    input  ilk_pkg::ilk_word_t  fifo_word,
    input  logic                fifo_valid,
    output logic                fifo_ready,
    output ilk_pkg::ilk_block_t line_block,
    output logic                line_valid,
    output logic                tx_active
);
    import ilk_pkg::*;

    localparam int            pw       = $clog2(METALEN);
    localparam logic [pw-1:0] pos_last = pw'(METALEN - 1);

    logic [pw-1:0] pos;  // position of the block being built
    logic          go;
    logic          pop;
    logic [31:0]   crc;
    ilk_block_t    next_block;

    assign go         = enable | line_valid;  // once started the line never stops
    assign fifo_ready = go && (pos != '0) && (pos != pos_last);  // data slots only
    assign pop        = fifo_ready & fifo_valid;
    assign tx_active  = line_valid;

    // block selection by metaframe position
    always_comb begin
        next_block = '0;
        if (pos == '0) begin
            next_block.hdr                = ilk_hdr_ctrl;
            next_block.payload.ctrl.btype = ilk_type_sync;
            next_block.payload.ctrl.value = ilk_sync_value;
        end else if (pos == pos_last) begin
            next_block.hdr                = ilk_hdr_ctrl;
            next_block.payload.ctrl.btype = ilk_type_diag;
            next_block.payload.ctrl.value = crc;  // covers this metaframe's words
        end else if (fifo_valid && fifo_word.ctrl) begin
            next_block.hdr                = ilk_hdr_ctrl;
            next_block.payload.ctrl.btype = ilk_type_user;
            next_block.payload.ctrl.value = fifo_word.data[31:0];  // low half only
        end else if (fifo_valid) begin
            next_block.hdr         = ilk_hdr_data;
            next_block.payload.raw = fifo_word.data;
        end else begin
            next_block.hdr                = ilk_hdr_ctrl;  // fifo empty
            next_block.payload.ctrl.btype = ilk_type_idle;
        end
    end

    // crc over the raw payload of every popped word, restarted at sync
    ilk_crc32 ilk_tx_crc_inst (
        .coreclk (coreclk),
        .arst_n  (arst_n),
        .clear   (go && (pos == '0)),
        .enable  (pop),
        .data    (next_block.payload.raw),
        .crc     (crc)
    );

    always_ff @(posedge coreclk or negedge arst_n) begin
        if (!arst_n) begin
            pos        <= '0;
            line_valid <= 1'b0;
        end else if (go) begin
            line_valid <= 1'b1;
            pos        <= (pos == pos_last) ? '0 : pos + 1'b1;
        end
    end

    always_ff @(posedge coreclk) begin
        if (go) begin
            line_block <= next_block;
        end
    end

endmodule

//--- hw/ilk_rx_deframer.sv
// rx deframer: sync lock fsm, control stripping and crc check, pushes words to the rx fifo
module ilk_rx_deframer #(
    parameter int METALEN = 64
) (
    input  logic                coreclk,
    input  logic                arst_n,
    input  ilk_pkg::ilk_block_t line_block,
    input  logic                line_valid,
    output ilk_pkg::ilk_word_t  out_word,
    output logic                out_valid,
    input  logic                out_ready,
    output logic                status_lock,
    output logic                align_seen,
    output logic                crc_err,
    output logic                overflow
);
    import ilk_pkg::*;

    localparam int            pw       = $clog2(METALEN);
    localparam logic [pw-1:0] pos_last = pw'(METALEN - 1);

    localparam logic [1:0] st_hunt   = 2'd0;  // looking for any sync
    localparam logic [1:0] st_verify = 2'd1;  // counting syncs at metaframe spacing
    localparam logic [1:0] st_locked = 2'd2;

    logic [1:0]    state;
    logic [pw-1:0] pos;       // position of the incoming block
    logic [1:0]    sync_cnt;  // syncs seen so far in verify
    logic          miss;      // last expected sync was absent
    logic          is_data;
    logic          is_ctrl;
    logic          is_sync;
    logic          is_diag;
    logic          is_user;
    logic          at_sync;
    logic          locked;
    logic          keep;      // block carries a user word
    logic [31:0]   crc;

    assign is_data = line_valid && (line_block.hdr == ilk_hdr_data);
    assign is_ctrl = line_valid && (line_block.hdr == ilk_hdr_ctrl);
    assign is_sync = is_ctrl && (line_block.payload.ctrl.btype == ilk_type_sync)
                     && (line_block.payload.ctrl.value == ilk_sync_value);
    assign is_diag = is_ctrl && (line_block.payload.ctrl.btype == ilk_type_diag);
    assign is_user = is_ctrl && (line_block.payload.ctrl.btype == ilk_type_user);
    assign at_sync = line_valid && (pos == '0);
    assign locked  = (state == st_locked);
    assign keep    = is_data | is_user;

    assign status_lock = locked;
    assign overflow    = out_valid & ~out_ready;  // fifo full, word dropped

    // lock fsm and position counter
    always_ff @(posedge coreclk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= st_hunt;
            pos        <= '0;
            sync_cnt   <= '0;
            miss       <= 1'b0;
            align_seen <= 1'b0;
        end else if (line_valid) begin
            pos <= (pos == pos_last) ? '0 : pos + 1'b1;
            if (is_sync) begin
                align_seen <= 1'b1;
            end
            case (state)
                st_hunt: begin
                    if (is_sync) begin
                        state    <= st_verify;
                        pos      <= pw'(1);  // realign on this sync
                        sync_cnt <= 2'd1;
                    end
                end
                st_verify: begin
                    if (at_sync) begin
                        if (!is_sync) begin
                            state <= st_hunt;
                        end else if (sync_cnt == 2'd3) begin
                            state <= st_locked;  // fourth sync
                            miss  <= 1'b0;
                        end else begin
                            sync_cnt <= sync_cnt + 1'b1;
                        end
                    end
                end
                st_locked: begin
                    if (at_sync) begin
                        if (is_sync) begin
                            miss <= 1'b0;
                        end else if (miss) begin
                            state <= st_hunt;  // second miss in a row
                        end else begin
                            miss <= 1'b1;
                        end
                    end
                end
                default: state <= st_hunt;
            endcase
        end
    end

    // receive side crc, same coverage as the framer
    ilk_crc32 ilk_rx_crc_inst (
        .coreclk (coreclk),
        .arst_n  (arst_n),
        .clear   (is_sync),
        .enable  (locked && keep),
        .data    (line_block.payload.raw),
        .crc     (crc)
    );

    always_ff @(posedge coreclk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            crc_err   <= 1'b0;
        end else begin
            out_valid <= locked && keep;  // idles and unlocked blocks dropped
            crc_err   <= locked && is_diag && (line_block.payload.ctrl.value != crc);
        end
    end

    always_ff @(posedge coreclk) begin
        if (keep) begin
            out_word.data <= is_user ? {32'h0, line_block.payload.ctrl.value}
                                     : line_block.payload.raw;
            out_word.ctrl <= is_user;
        end
    end

endmodule

//--- hw/ilk_mgmt_csr.sv
// management register block: control, status and error counters behind the 9-bit mgmt port
module ilk_mgmt_csr #(
    parameter int METALEN = 64
) (
    input  logic                 coreclk,
    input  logic                 arst_n,
    input  logic                 mgmt_read,
    input  logic                 mgmt_write,
    input  logic [8:0]           mgmt_address,
    input  logic [31:0]          mgmt_writedata,
    output logic [31:0]          mgmt_readdata,
    output logic                 mgmt_readvalid,
    output logic                 tx_enable,
    input  ilk_pkg::ilk_status_t status,
    input  logic                 crc_err,
    input  logic                 overflow
);
    import ilk_pkg::*;

    logic [31:0] crc_err_cnt;
    logic [31:0] ovf_cnt;
    logic [31:0] rd_mux;
    logic        wr_csr;  // write into the csr space, bit 8 low

    assign wr_csr = mgmt_write & ~mgmt_address[8];

    // write clears, else count up and hold at all ones
    function automatic logic [31:0] cnt_next(input logic [31:0] cnt, input logic clr,
                                             input logic inc);
        logic [31:0] r;
        r = cnt;
        if (clr) begin
            r = '0;
        end else if (inc && (cnt != '1)) begin
            r = cnt + 1'b1;
        end
        return r;
    endfunction

    always_comb begin
        rd_mux = '0;  // reserved space and unlisted offsets
        if (!mgmt_address[8]) begin
            case (mgmt_address[7:0])
                ilk_csr_control: rd_mux = {31'h0, tx_enable};
                ilk_csr_status:  rd_mux = {29'h0, status};
                ilk_csr_crc_err: rd_mux = crc_err_cnt;
                ilk_csr_ovf:     rd_mux = ovf_cnt;
                ilk_csr_metalen: rd_mux = 32'(METALEN);
                default:         rd_mux = '0;
            endcase
        end
    end

    always_ff @(posedge coreclk or negedge arst_n) begin
        if (!arst_n) begin
            tx_enable      <= 1'b0;
            crc_err_cnt    <= '0;
            ovf_cnt        <= '0;
            mgmt_readvalid <= 1'b0;
        end else begin
            mgmt_readvalid <= mgmt_read;
            if (wr_csr && (mgmt_address[7:0] == ilk_csr_control)) begin
                tx_enable <= mgmt_writedata[0];
            end
            crc_err_cnt <= cnt_next(crc_err_cnt,
                                    wr_csr && (mgmt_address[7:0] == ilk_csr_crc_err), crc_err);
            ovf_cnt     <= cnt_next(ovf_cnt,
                                    wr_csr && (mgmt_address[7:0] == ilk_csr_ovf), overflow);
        end
    end

    always_ff @(posedge coreclk) begin
        if (mgmt_read) begin
            mgmt_readdata <= rd_mux;  // valid with mgmt_readvalid
        end
    end

endmodule

//--- hw/ilk_lane.sv
// single lane pcs top: user fifos, framer, deframer and csr block on one core clock
module ilk_lane #(
    parameter int METALEN       = 64,
    parameter int TX_FIFO_DEPTH = 16,
    parameter int RX_FIFO_DEPTH = 16
) (
    input  logic                coreclk,
    input  logic                arst_n,
    // user tx
    input  ilk_pkg::ilk_word_t  tx_word,
    input  logic                tx_valid,
    output logic                tx_ready,
    // user rx
    output ilk_pkg::ilk_word_t  rx_word,
    output logic                rx_valid,
    input  logic                rx_ready,
    // line, looped back outside
    output ilk_pkg::ilk_block_t line_tx_block,
    output logic                line_tx_valid,
    input  ilk_pkg::ilk_block_t line_rx_block,
    input  logic                line_rx_valid,
    // management
    input  logic                mgmt_read,
    input  logic                mgmt_write,
    input  logic [8:0]          mgmt_address,
    input  logic [31:0]         mgmt_writedata,
    output logic [31:0]         mgmt_readdata,
    output logic                mgmt_readvalid,
    output logic                frame_lock
);
    import ilk_pkg::*;

    ilk_word_t   tx_fifo_word;
    logic        tx_fifo_valid;
    logic        tx_fifo_ready;
    logic        tx_fifo_wr_ready;
    ilk_word_t   rx_push_word;
    logic        rx_push_valid;
    logic        rx_push_ready;
    logic        tx_enable;
    logic        tx_active;
    logic        align_seen;
    logic        crc_err;
    logic        overflow;
    ilk_status_t status;

    assign tx_ready = tx_fifo_wr_ready & tx_enable;  // no pushes while disabled
    assign status   = '{tx_ready: tx_active, frame_lock: frame_lock, align_seen: align_seen};

    ilk_fifo #(.DEPTH(TX_FIFO_DEPTH)) ilk_tx_fifo_inst (
        .coreclk (coreclk),
        .arst_n  (arst_n),
        .wr_word (tx_word),
        .wr_valid(tx_valid & tx_enable),
        .wr_ready(tx_fifo_wr_ready),
        .rd_word (tx_fifo_word),
        .rd_valid(tx_fifo_valid),
        .rd_ready(tx_fifo_ready)
    );

    ilk_tx_framer #(.METALEN(METALEN)) ilk_tx_framer_inst (
        .coreclk   (coreclk),
        .arst_n    (arst_n),
        .enable    (tx_enable),
        .fifo_word (tx_fifo_word),
        .fifo_valid(tx_fifo_valid),
        .fifo_ready(tx_fifo_ready),
        .line_block(line_tx_block),
        .line_valid(line_tx_valid),
        .tx_active (tx_active)
    );

    ilk_rx_deframer #(.METALEN(METALEN)) ilk_rx_deframer_inst (
        .coreclk    (coreclk),
        .arst_n     (arst_n),
        .line_block (line_rx_block),
        .line_valid (line_rx_valid),
        .out_word   (rx_push_word),
        .out_valid  (rx_push_valid),
        .out_ready  (rx_push_ready),
        .status_lock(frame_lock),
        .align_seen (align_seen),
        .crc_err    (crc_err),
        .overflow   (overflow)
    );

    ilk_fifo #(.DEPTH(RX_FIFO_DEPTH)) ilk_rx_fifo_inst (
        .coreclk (coreclk),
        .arst_n  (arst_n),
        .wr_word (rx_push_word),
        .wr_valid(rx_push_valid),
        .wr_ready(rx_push_ready),
        .rd_word (rx_word),
        .rd_valid(rx_valid),
        .rd_ready(rx_ready)
    );

    ilk_mgmt_csr #(.METALEN(METALEN)) ilk_mgmt_csr_inst (
        .coreclk       (coreclk),
        .arst_n        (arst_n),
        .mgmt_read     (mgmt_read),
        .mgmt_write    (mgmt_write),
        .mgmt_address  (mgmt_address),
        .mgmt_writedata(mgmt_writedata),
        .mgmt_readdata (mgmt_readdata),
        .mgmt_readvalid(mgmt_readvalid),
        .tx_enable     (tx_enable),
        .status        (status),
        .crc_err       (crc_err),
        .overflow      (overflow)
    );

endmodule

//--- testbench/ilk_lane_tb.sv
// top-level loopback testbench that drives every lane port and scoreboards the rx words
module ilk_lane_tb;
    import ilk_pkg::*;

    localparam int metalen    = 16;
    localparam int lock_limit = 6 * metalen;  // cycles allowed from tx_enable to lock

    logic        coreclk = 1'b0;
    logic        arst_n;
    ilk_word_t   tx_word;
    logic        tx_valid;
    logic        tx_ready;
    ilk_word_t   rx_word;
    logic        rx_valid;
    logic        rx_ready = 1'b0;
    ilk_block_t  line_tx_block;
    logic        line_tx_valid;
    ilk_block_t  line_rx_block;
    logic        line_rx_valid;
    logic        mgmt_read;
    logic        mgmt_write;
    logic [8:0]  mgmt_address;
    logic [31:0] mgmt_writedata;
    logic [31:0] mgmt_readdata;
    logic        mgmt_readvalid;
    logic        frame_lock;

    ilk_word_t exp_q[$];            // accepted tx words in send order
    int        errors        = 0;
    int        err_mark      = 0;   // error count when the current test began
    int        pass_count    = 0;
    int        fail_count    = 0;
    int        cycle         = 0;
    int        rx_count      = 0;
    int        line_words    = 0;   // data and user blocks seen on the line
    int        line_diags    = 0;
    int        line_pos      = 0;   // metaframe position of the block on the line
    int        rx_mode       = 0;   // 0 held low, 1 always ready, 2 random
    logic      lock_hold     = 1'b0;
    logic      corrupt_armed = 1'b0;
    logic      flip_now      = 1'b0;  // payload bit 0 inverted on the loopback
    logic      flip_expected = 1'b0;

    ilk_lane #(
        .METALEN      (metalen),
        .RX_FIFO_DEPTH(8)
    ) ilk_lane_inst (
        .coreclk       (coreclk),
        .arst_n        (arst_n),
        .tx_word       (tx_word),
        .tx_valid      (tx_valid),
        .tx_ready      (tx_ready),
        .rx_word       (rx_word),
        .rx_valid      (rx_valid),
        .rx_ready      (rx_ready),
        .line_tx_block (line_tx_block),
        .line_tx_valid (line_tx_valid),
        .line_rx_block (line_rx_block),
        .line_rx_valid (line_rx_valid),
        .mgmt_read     (mgmt_read),
        .mgmt_write    (mgmt_write),
        .mgmt_address  (mgmt_address),
        .mgmt_writedata(mgmt_writedata),
        .mgmt_readdata (mgmt_readdata),
        .mgmt_readvalid(mgmt_readvalid),
        .frame_lock    (frame_lock)
    );

    always #2 coreclk = ~coreclk;

    always @(posedge coreclk) cycle <= cycle + 1;

    // loopback with an optional bit error on one data block
    always_comb begin
        line_rx_block                = line_tx_block;
        line_rx_block.payload.raw[0] = line_tx_block.payload.raw[0] ^ flip_now;
    end
    assign line_rx_valid = line_tx_valid;

    // line watcher sampled mid cycle where the block is stable
    always @(negedge coreclk) begin
        flip_now = 1'b0;
        if (line_tx_valid) begin
            if (line_pos == 0) begin
                assert ((line_tx_block.hdr == ilk_hdr_ctrl)
                        && (line_tx_block.payload.ctrl.btype == ilk_type_sync)
                        && (line_tx_block.payload.ctrl.value == ilk_sync_value)) else begin
                    errors++;
                    $display("MISMATCH %0t: no sync word at metaframe position 0", $time);
                end
            end else if (line_pos == metalen - 1) begin
                assert ((line_tx_block.hdr == ilk_hdr_ctrl)
                        && (line_tx_block.payload.ctrl.btype == ilk_type_diag)) else begin
                    errors++;
                    $display("MISMATCH %0t: no diagnostic word at the last position", $time);
                end
            end else begin
                assert ((line_tx_block.hdr == ilk_hdr_data)
                        || ((line_tx_block.hdr == ilk_hdr_ctrl)
                        && ((line_tx_block.payload.ctrl.btype == ilk_type_user)
                        || (line_tx_block.payload.ctrl.btype == ilk_type_idle)))) else begin
                    errors++;
                    $display("MISMATCH %0t: block at position %0d is not data, user or idle",
                             $time, line_pos);
                end
            end
            line_pos = (line_pos + 1) % metalen;  // counted from the first valid block
            if ((line_tx_block.hdr == ilk_hdr_data) || ((line_tx_block.hdr == ilk_hdr_ctrl)
                    && (line_tx_block.payload.ctrl.btype == ilk_type_user))) begin
                line_words++;
            end
            if ((line_tx_block.hdr == ilk_hdr_ctrl)
                    && (line_tx_block.payload.ctrl.btype == ilk_type_diag)) begin
                line_diags++;
            end
            if (corrupt_armed && (line_tx_block.hdr == ilk_hdr_data)) begin
                flip_now      = 1'b1;  // held across the next rising edge
                corrupt_armed = 1'b0;
            end
        end
    end

    // scoreboard check of every word the user side takes
    always @(negedge coreclk) begin : rx_monitor
        ilk_word_t want;
        if (rx_valid && rx_ready) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("%0t: a word came out of the lane that was never sent", $time);
            end else begin
                want = exp_q.pop_front();
                if (flip_expected) begin
                    want.data[0]  = ~want.data[0];  // bit hit on the line
                    flip_expected = 1'b0;
                end
                assert (rx_word == want) else begin
                    errors++;
                    $display("MISMATCH %0t: rx word %h ctrl %b, expected %h ctrl %b",
                             $time, rx_word.data, rx_word.ctrl, want.data, want.ctrl);
                end
            end
            rx_count++;
        end
    end

    // rx back-pressure pattern
    always @(posedge coreclk) begin
        #1;
        case (rx_mode)
            1:       rx_ready = 1'b1;
            2:       rx_ready = ($urandom_range(7) != 0);  // mostly ready
            default: rx_ready = 1'b0;
        endcase
    end

    readvalid_follows_read: assert property (@(posedge coreclk) disable iff (!arst_n)
            mgmt_readvalid == $past(mgmt_read)) else begin
        errors++;
        $display("MISMATCH %0t: mgmt_readvalid not exactly one cycle after mgmt_read", $time);
    end

    lock_stays_high: assert property (@(posedge coreclk) disable iff (!arst_n)
            lock_hold |-> frame_lock) else begin
        errors++;
        $display("MISMATCH %0t: frame_lock dropped in clean loopback", $time);
    end

    line_stays_valid: assert property (@(posedge coreclk) disable iff (!arst_n)
            line_tx_valid |=> line_tx_valid) else begin
        errors++;
        $display("MISMATCH %0t: line_tx_valid dropped after the line started", $time);
    end

    task automatic close_run();
        $display("tests passed %0d, failed %0d, errors %0d", pass_count, fail_count, errors);
        if ((fail_count == 0) && (errors == 0)) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    task automatic timed_out(input string what);
        $display("%0t: timeout waiting for %s", $time, what);
        errors++;
        fail_count++;
        close_run();
    endtask

    task automatic next_cycle();  // just after the next rising edge
        @(posedge coreclk);
        #1;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic compare_value(input string what, input logic [63:0] got,
                                 input logic [63:0] want);
        assert (got === want) else begin
            errors++;
            $display("MISMATCH %0t: %s is %0h, expected %0h", $time, what, got, want);
        end
    endtask

    task automatic end_test(input string name);
        if (errors == err_mark) begin
            pass_count++;
            $display("test %s: pass", name);
        end else begin
            fail_count++;
            $display("test %s: fail", name);
        end
        err_mark = errors;
    endtask

    task automatic csr_write(input logic [8:0] addr, input logic [31:0] data);
        mgmt_write     = 1'b1;
        mgmt_address   = addr;
        mgmt_writedata = data;
        next_cycle();
        mgmt_write = 1'b0;
    endtask

    task automatic csr_read(input logic [8:0] addr, output logic [31:0] data);
        int n;
        mgmt_read    = 1'b1;
        mgmt_address = addr;
        next_cycle();
        mgmt_read = 1'b0;
        n = 0;
        while (!mgmt_readvalid && (n < 4)) begin
            next_cycle();
            n++;
        end
        if (!mgmt_readvalid) timed_out("mgmt_readvalid");
        data = mgmt_readdata;
    endtask

    // user control words carry only 32 bits in the value field
    function automatic ilk_word_t expected_rx(input ilk_word_t w);
        ilk_word_t r;
        r = w;
        if (w.ctrl) begin
            r.data[63:32] = '0;
        end
        return r;
    endfunction

    function automatic ilk_word_t random_word();
        ilk_word_t w;
        w.data = {$urandom, $urandom};
        w.ctrl = ($urandom_range(3) == 0);
        return w;
    endfunction

    task automatic send_word(input ilk_word_t w);
        int n;
        tx_word  = w;
        tx_valid = 1'b1;
        n = 0;
        while (!tx_ready && (n < 200)) begin
            next_cycle();
            n++;
        end
        if (!tx_ready) timed_out("tx_ready");
        exp_q.push_back(expected_rx(w));
        next_cycle();  // taken on this edge
        tx_valid = 1'b0;
    endtask

    task automatic wait_drained(input int limit);
        int n;
        n = 0;
        while ((exp_q.size() != 0) && (n < limit)) begin
            next_cycle();
            n++;
        end
        if (exp_q.size() != 0) timed_out("all sent words to arrive");
    endtask

    initial begin : stimulus
        logic [31:0] rd;
        int          n;
        int          mark;
        ilk_word_t   w;
        void'($urandom(32'h0ad218d3));
        arst_n         = 1'b0;
        tx_word        = '0;
        tx_valid       = 1'b0;
        mgmt_read      = 1'b0;
        mgmt_write     = 1'b0;
        mgmt_address   = '0;
        mgmt_writedata = '0;
        repeat (3) @(posedge coreclk);
        #1;
        arst_n = 1'b1;
        next_cycle();

        compare_value("tx_ready after reset", tx_ready, 0);
        compare_value("line_tx_valid after reset", line_tx_valid, 0);
        compare_value("rx_valid after reset", rx_valid, 0);
        compare_value("mgmt_readvalid after reset", mgmt_readvalid, 0);
        compare_value("frame_lock after reset", frame_lock, 0);
        csr_read(ilk_csr_status, rd);
        compare_value("status after reset", rd, 0);
        end_test("reset state");

        csr_write(ilk_csr_control, 32'h0);
        csr_read(ilk_csr_control, rd);
        compare_value("control", rd, 0);
        csr_read(ilk_csr_metalen, rd);
        compare_value("metaframe length", rd, metalen);
        csr_read({1'b1, ilk_csr_metalen}, rd);  // reserved space
        compare_value("reserved read", rd, 0);
        csr_write({1'b1, ilk_csr_control}, 32'h1);
        csr_read(ilk_csr_control, rd);
        compare_value("control after reserved write", rd, 0);
        compare_value("line_tx_valid after reserved write", line_tx_valid, 0);
        end_test("csr access");

        mark = cycle;
        csr_write(ilk_csr_control, 32'h1);
        csr_read(ilk_csr_control, rd);
        compare_value("control", rd, 1);
        rd = '0;
        while (!rd[0] && ((cycle - mark) < lock_limit)) begin
            csr_read(ilk_csr_status, rd);
        end
        if (!rd[0]) timed_out("align_seen in status");
        compare_value("frame_lock bit when align first seen", rd[1], 0);
        while (!frame_lock && ((cycle - mark) < lock_limit)) begin
            next_cycle();
        end
        if (!frame_lock) timed_out("frame_lock");
        lock_hold = 1'b1;
        csr_read(ilk_csr_status, rd);
        compare_value("status in lock", rd, 32'h7);
        end_test("lock");

        rx_mode = 2;
        for (int i = 0; i < 200; i++) begin
            send_word(random_word());
            idle_cycles($urandom_range(2));  // keeps the rx fifo from filling
        end
        wait_drained(4000);
        csr_read(ilk_csr_crc_err, rd);
        compare_value("crc error count", rd, 0);
        csr_read(ilk_csr_ovf, rd);
        compare_value("overflow count", rd, 0);
        end_test("data integrity");

        rx_mode       = 1;
        mark          = rx_count;
        corrupt_armed = 1'b1;
        flip_expected = 1'b1;
        w.data        = {$urandom, $urandom};
        w.ctrl        = 1'b0;
        send_word(w);
        n = 0;
        while ((rx_count == mark) && (n < 4 * metalen)) begin
            next_cycle();
            n++;
        end
        if (rx_count == mark) timed_out("the corrupted word");
        mark = line_diags;
        n = 0;
        while ((line_diags == mark) && (n < 2 * metalen)) begin
            next_cycle();
            n++;
        end
        if (line_diags == mark) timed_out("a diagnostic block");
        idle_cycles(3);  // crc_err pulse then counter update
        compare_value("frame_lock after corruption", frame_lock, 1);
        csr_read(ilk_csr_crc_err, rd);
        compare_value("crc error count", rd, 1);
        end_test("crc detection");

        rx_mode = 0;
        idle_cycles(1);
        mark = line_words;
        for (int i = 0; i < 12; i++) begin
            send_word(random_word());
        end
        n = 0;
        while ((line_words < mark + 12) && (n < 4 * metalen)) begin
            next_cycle();
            n++;
        end
        if (line_words < mark + 12) timed_out("12 words on the line");
        idle_cycles(4);  // deframer and fifo stages
        csr_read(ilk_csr_ovf, rd);
        compare_value("overflow count", rd, 4);
        repeat (4) void'(exp_q.pop_back());  // the last four never fit
        rx_mode = 1;
        wait_drained(4 * metalen);
        idle_cycles(4);
        compare_value("rx_valid after drain", rx_valid, 0);
        csr_write(ilk_csr_ovf, 32'h1234);
        csr_read(ilk_csr_ovf, rd);
        compare_value("overflow count after clear", rd, 0);
        end_test("overflow");

        close_run();
    end

endmodule

//--- project.f
hw/ilk_pkg.sv
hw/ilk_fifo.sv
hw/ilk_crc32.sv
hw/ilk_tx_framer.sv
hw/ilk_rx_deframer.sv
hw/ilk_mgmt_csr.sv
hw/ilk_lane.sv
testbench/ilk_lane_tb.sv
